//--- compile.f
design/iob_bus_pkg.sv
design/wb_mem_pkg.sv
design/iob2wishbone.sv
design/wb_sram.sv
design/iob_wb_top.sv
dv/tb_clock_gen.sv
dv/iob_wb_checker.sv
dv/iob_wb_tb.sv

//--- design/iob2wishbone.sv
`timescale 1ns/10ps

module iob2wishbone
   import iob_bus_pkg::*;
(
   input  logic              clk_i,
   input  logic              reset_i,

   // IOb side
   input  logic              iob_avalid_i,
   input  logic [ADDR_W-1:0] iob_addr_i,
   input  logic [DATA_W-1:0] iob_wdata_i,
   input  logic [STRB_W-1:0] iob_wstrb_i,
   output logic              iob_rvalid_o,
   output logic [DATA_W-1:0] iob_rdata_o,
   output logic              iob_ready_o,

   // Wishbone side
   output logic [ADDR_W-1:0] wb_addr_o,
   output logic [DATA_W-1:0] wb_data_o,
   output logic [STRB_W-1:0] wb_select_o,
   output logic              wb_we_o,
   output logic              wb_cyc_o,
   output logic              wb_stb_o,
   input  logic              wb_ack_i,
   input  logic [DATA_W-1:0] wb_data_i
);

   logic              avalid_r;
   logic              ack_r;
   logic [ADDR_W-1:0] addr_r;
   logic [DATA_W-1:0] wdata_r;
   logic [STRB_W-1:0] sel_r;
   logic              we_r;
   logic [DATA_W-1:0] rdata_r;

   logic              req_we;
   logic [STRB_W-1:0] req_sel;

   // any strobe bit makes it a write
   assign req_we = |iob_wstrb_i;

   // reads select READ_BYTES lanes starting at the byte offset
   assign req_sel = req_we ? iob_wstrb_i : STRB_W'(RB_MASK << iob_addr_i[1:0]);

   // live request in the accept cycle, held copy until the ack
   assign wb_addr_o   = iob_avalid_i ? iob_addr_i : addr_r;
   assign wb_data_o   = iob_avalid_i ? iob_wdata_i : wdata_r;
   assign wb_select_o = iob_avalid_i ? req_sel : sel_r;
   assign wb_we_o     = iob_avalid_i ? req_we : we_r;
   assign wb_stb_o    = iob_avalid_i | avalid_r;
   assign wb_cyc_o    = wb_stb_o;

   assign iob_rvalid_o = ack_r & ~we_r;
   assign iob_rdata_o  = rdata_r;
   assign iob_ready_o  = ~avalid_r | ack_r;

   // outstanding flag clears on the ack, registered ack closes the transfer
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         avalid_r <= 1'b0;
         ack_r    <= 1'b0;
      end else begin
         if (iob_avalid_i | wb_ack_i) begin
            avalid_r <= iob_avalid_i;
         end
         ack_r <= wb_ack_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (iob_avalid_i) begin
         addr_r  <= iob_addr_i;
         wdata_r <= iob_wdata_i;
         sel_r   <= req_sel;
         we_r    <= req_we;
      end
      rdata_r <= wb_data_i;
   end

   // master must wait for ready before a new request
   a_no_req_while_busy : assert property (
      @(posedge clk_i) disable iff (reset_i)
      iob_avalid_i |-> iob_ready_o
   );

   // slave only acks a strobe that is still up
   a_ack_inside_strobe : assert property (
      @(posedge clk_i) disable iff (reset_i)
      wb_ack_i |-> wb_stb_o
   );

endmodule

//--- design/iob_bus_pkg.sv
package iob_bus_pkg;

   // byte address and data widths of the IOb side
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;

   // one strobe bit per byte lane
   localparam int STRB_W = DATA_W / 8;

   // a read always asks for this many bytes
   localparam int READ_BYTES = 4;

   // read select before alignment
   // a zero sits above the ones so the shifted value drops lanes past the word
   localparam logic [READ_BYTES:0] RB_MASK = {1'b0, {READ_BYTES{1'b1}}};

endpackage

//--- design/iob_wb_top.sv
`timescale 1ns/10ps

module iob_wb_top
   import iob_bus_pkg::*;
(
   input  logic              clk_i,
   input  logic              reset_i,
   input  logic              iob_avalid_i,
   input  logic [ADDR_W-1:0] iob_addr_i,
   input  logic [DATA_W-1:0] iob_wdata_i,
   input  logic [STRB_W-1:0] iob_wstrb_i,
   output logic              iob_rvalid_o,
   output logic [DATA_W-1:0] iob_rdata_o,
   output logic              iob_ready_o
);

   logic [ADDR_W-1:0] wb_addr;
   logic [DATA_W-1:0] wb_data_w;
   logic [STRB_W-1:0] wb_sel;
   logic              wb_we;
   logic              wb_cyc;
   logic              wb_stb;
   logic              wb_ack;
   logic [DATA_W-1:0] wb_data_r;

   iob2wishbone iob2wishbone_inst (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .iob_avalid_i(iob_avalid_i),
      .iob_addr_i  (iob_addr_i),
      .iob_wdata_i (iob_wdata_i),
      .iob_wstrb_i (iob_wstrb_i),
      .iob_rvalid_o(iob_rvalid_o),
      .iob_rdata_o (iob_rdata_o),
      .iob_ready_o (iob_ready_o),
      .wb_addr_o   (wb_addr),
      .wb_data_o   (wb_data_w),
      .wb_select_o (wb_sel),
      .wb_we_o     (wb_we),
      .wb_cyc_o    (wb_cyc),
      .wb_stb_o    (wb_stb),
      .wb_ack_i    (wb_ack),
      .wb_data_i   (wb_data_r)
   );

   wb_sram wb_sram_inst (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .wb_cyc_i (wb_cyc),
      .wb_stb_i (wb_stb),
      .wb_we_i  (wb_we),
      .wb_addr_i(wb_addr),
      .wb_sel_i (wb_sel),
      .wb_data_i(wb_data_w),
      .wb_ack_o (wb_ack),
      .wb_data_o(wb_data_r)
   );

endmodule

//--- design/wb_mem_pkg.sv
package wb_mem_pkg;

   // word memory size and index width
   localparam int MEM_DEPTH = 64;
   localparam int MEM_AW = 6;

   // wait states between strobe and ack
   localparam int WB_WAIT_CYCLES = 2;

   // counter wide enough to hold the wait count
   localparam int WAIT_CNT_W = $clog2(WB_WAIT_CYCLES + 1);

   // slave access sequence
   typedef enum logic [1:0] {
      MEM_IDLE,
      MEM_WAIT,
      MEM_ACK
   } wb_mem_state_t;

endpackage

//--- design/wb_sram.sv
`timescale 1ns/10ps

module wb_sram
   import iob_bus_pkg::*, wb_mem_pkg::*;
(
   input  logic              clk_i,
   input  logic              reset_i,
   input  logic              wb_cyc_i,
   input  logic              wb_stb_i,
   input  logic              wb_we_i,
   input  logic [ADDR_W-1:0] wb_addr_i,
   input  logic [STRB_W-1:0] wb_sel_i,
   input  logic [DATA_W-1:0] wb_data_i,
   output logic              wb_ack_o,
   output logic [DATA_W-1:0] wb_data_o
);

   logic [DATA_W-1:0] mem [MEM_DEPTH];

   wb_mem_state_t     state_q;
   wb_mem_state_t     state_d;
   logic [WAIT_CNT_W-1:0] wait_cnt_q;
   logic              wait_done;
   logic [MEM_AW-1:0] word_idx;
   logic [DATA_W-1:0] rdata_q;

   // byte address down to word index so upper bits wrap
   assign word_idx = wb_addr_i[MEM_AW+1:2];

   assign wait_done = (state_q == MEM_WAIT) &&
                      (wait_cnt_q == WAIT_CNT_W'(WB_WAIT_CYCLES - 1));

   always_comb begin
      state_d = state_q;
      case (state_q)
         MEM_IDLE: begin
            if (wb_cyc_i && wb_stb_i) begin
               state_d = MEM_WAIT;
            end
         end
         MEM_WAIT: begin
            if (wait_done) begin
               state_d = MEM_ACK;
            end
         end
         default: state_d = MEM_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q    <= MEM_IDLE;
         wait_cnt_q <= '0;
      end else begin
         state_q <= state_d;
         if (state_q == MEM_WAIT) begin
            wait_cnt_q <= wait_cnt_q + 1'b1;
         end else begin
            wait_cnt_q <= '0;
         end
      end
   end

   // fetch the word on the last wait so it is ready for the ack cycle
   always_ff @(posedge clk_i) begin
      if (wait_done) begin
         rdata_q <= mem[word_idx];
      end
   end

   // byte lane writes land at the end of the ack cycle
   always_ff @(posedge clk_i) begin
      if (state_q == MEM_ACK && wb_we_i) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (wb_sel_i[b]) begin
               mem[word_idx][8*b +: 8] <= wb_data_i[8*b +: 8];
            end
         end
      end
   end

   assign wb_ack_o  = (state_q == MEM_ACK);
   assign wb_data_o = (state_q == MEM_ACK && !wb_we_i) ? rdata_q : '0;

   // ack follows a new strobe after the wait states and lasts one cycle
   a_ack_single : assert property (
      @(posedge clk_i) disable iff (reset_i)
      (state_q == MEM_IDLE && wb_cyc_i && wb_stb_i) |->
         ##(WB_WAIT_CYCLES + 1) wb_ack_o ##1 !wb_ack_o
   );

   // the master holds its strobe through the wait states
   a_wait_needs_stb : assert property (
      @(posedge clk_i) disable iff (reset_i)
      (state_q == MEM_WAIT) |-> wb_stb_i
   );

endmodule

//--- dv/iob_wb_checker.sv
`timescale 1ns/10ps

module iob_wb_checker
   import iob_bus_pkg::*;
(
   input  logic              clk_i,
   input  logic              reset_i,
   input  logic              iob_avalid_i,
   input  logic [STRB_W-1:0] iob_wstrb_i,
   input  logic              iob_ready_i,
   input  logic              iob_rvalid_i,
   input  logic [DATA_W-1:0] iob_rdata_i,
   output int                data_errors_o,
   output int                timing_errors_o,
   output int                pending_o
);

   string             name_q[$];
   logic [DATA_W-1:0] data_q[$];
   int                data_errs = 0;
   int                timing_errs = 0;
   int                pending = 0;
   int                since_accept = 0;
   logic              read_open = 1'b0;

   assign data_errors_o   = data_errs;
   assign timing_errors_o = timing_errs;
   assign pending_o       = pending;

   task automatic expect_read(input string name, input logic [DATA_W-1:0] data);
      name_q.push_back(name);
      data_q.push_back(data);
   endtask

   // sampled mid cycle, away from both the clock edge and the input changes
   always @(negedge clk_i) begin
      string             name;
      logic [DATA_W-1:0] exp;
      if (reset_i) begin
         since_accept = 0;
      end else begin
         if (since_accept >= 1 && since_accept <= 3 && iob_ready_i) begin
            $display("ready was high %0d cycles after a request was accepted", since_accept);
            timing_errs++;
         end
         if ((since_accept == 0 || since_accept == 4) && !iob_ready_i) begin
            $display("ready was low with no transfer outstanding");
            timing_errs++;
         end
         if (iob_rvalid_i != (since_accept == 4 && read_open)) begin
            $display("rvalid was %0b at %0d cycles after acceptance", iob_rvalid_i, since_accept);
            timing_errs++;
         end
         if (iob_rvalid_i) begin
            if (data_q.size() == 0) begin
               $display("read data came back with no read waiting for it");
               timing_errs++;
            end else begin
               name = name_q.pop_front();
               exp = data_q.pop_front();
               if (iob_rdata_i !== exp) begin
                  $display("error %s: expected %h, actual %h", name, exp, iob_rdata_i);
                  data_errs++;
               end
            end
         end
         if (iob_avalid_i && iob_ready_i) begin
            since_accept = 1;
            read_open = (iob_wstrb_i == '0);
         end else if (since_accept != 0) begin
            since_accept = (since_accept == 4) ? 0 : since_accept + 1;
         end
      end
      pending = data_q.size();
   end

endmodule

//--- dv/iob_wb_tb.sv
`timescale 1ns/10ps

module iob_wb_tb
   import iob_bus_pkg::*, wb_mem_pkg::*;
();

   logic clk_i;
   logic reset_i;
   logic iob_avalid_i;
   logic [ADDR_W-1:0] iob_addr_i;
   logic [DATA_W-1:0] iob_wdata_i;
   logic [STRB_W-1:0] iob_wstrb_i;
   logic iob_rvalid_o;
   logic [DATA_W-1:0] iob_rdata_o;
   logic iob_ready_o;
   int data_errors;
   int timing_errors;
   int pending;
   int num_vecs = 0;

   string vec_name[$];
   logic [ADDR_W-1:0] vec_addr[$];
   logic [DATA_W-1:0] vec_wdata[$];
   logic [STRB_W-1:0] vec_wstrb[$];
   logic [DATA_W-1:0] vec_rdata[$];

   tb_clock_gen tb_clock_gen_inst (.clk_o(clk_i));

   iob_wb_top iob_wb_top_inst (
      .clk_i(clk_i), .reset_i(reset_i), .iob_avalid_i(iob_avalid_i),
      .iob_addr_i(iob_addr_i), .iob_wdata_i(iob_wdata_i), .iob_wstrb_i(iob_wstrb_i),
      .iob_rvalid_o(iob_rvalid_o), .iob_rdata_o(iob_rdata_o), .iob_ready_o(iob_ready_o)
   );

   iob_wb_checker iob_wb_checker_inst (
      .clk_i(clk_i), .reset_i(reset_i), .iob_avalid_i(iob_avalid_i),
      .iob_wstrb_i(iob_wstrb_i), .iob_ready_i(iob_ready_o), .iob_rvalid_i(iob_rvalid_o),
      .iob_rdata_i(iob_rdata_o), .data_errors_o(data_errors),
      .timing_errors_o(timing_errors), .pending_o(pending)
   );

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      logic fb;
      fb = state[31] ^ state[21] ^ state[1] ^ state[0];
      return {state[30:0], fb};
   endfunction

   task automatic next_cycle();
      @(posedge clk_i);
      #1;
   endtask

   task automatic load_vectors();
      int fd;
      int rc;
      string line;
      string name;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
      logic [DATA_W-1:0] rdata;
      fd = $fopen("dv/iob_wb_vectors.txt", "r");
      if (fd == 0) begin
         $display("could not open the vector file");
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         rc = $fgets(line, fd);
         if (rc > 1 && line[0] != "#") begin
            rc = $sscanf(line, "%s %h %h %h %h", name, addr, wdata, wstrb, rdata);
            if (rc == 5) begin
               vec_name.push_back(name);
               vec_addr.push_back(addr);
               vec_wdata.push_back(wdata);
               vec_wstrb.push_back(wstrb);
               vec_rdata.push_back(rdata);
            end
         end
      end
      $fclose(fd);
      num_vecs = vec_name.size();
   endtask

   // one request held for exactly one cycle
   task automatic send_request(input int i);
      iob_avalid_i = 1'b1;
      iob_addr_i = vec_addr[i];
      iob_wdata_i = vec_wdata[i];
      iob_wstrb_i = vec_wstrb[i];
      if (vec_wstrb[i] == '0) begin
         iob_wb_checker_inst.expect_read(vec_name[i], vec_rdata[i]);
      end
      next_cycle();
      iob_avalid_i = 1'b0;
      iob_addr_i = '0;
      iob_wdata_i = '0;
      iob_wstrb_i = '0;
   endtask

   task automatic wait_ready();
      while (!iob_ready_o) begin
         next_cycle();
      end
   endtask

   initial begin
      logic [31:0] lfsr;
      logic [1:0] gap;
      reset_i = 1'b1;
      iob_avalid_i = 1'b0;
      iob_addr_i = '0;
      iob_wdata_i = '0;
      iob_wstrb_i = '0;
      lfsr = 32'h068ee689;
      load_vectors();
      if (num_vecs == 0) begin
         $display("no request could be read from the vector file");
         $display("Some tests failed");
         $finish;
      end else begin
         repeat (10) @(posedge clk_i);
         #1;
         reset_i = 1'b0;
         for (int i = 0; i < num_vecs; i++) begin
            lfsr = lfsr_step(lfsr);
            gap[0] = lfsr[0];
            lfsr = lfsr_step(lfsr);
            gap[1] = lfsr[0];
            // back to back group goes out as soon as ready allows
            if (vec_name[i].substr(0, 2) == "b2b") begin
               gap = 2'd0;
            end
            wait_ready();
            repeat (gap) next_cycle();
            send_request(i);
         end
         wait_ready();
         next_cycle();
         next_cycle();
         $display("errors: data %0d, timing %0d, reads never returned %0d",
                  data_errors, timing_errors, pending);
         if (data_errors == 0 && timing_errors == 0 && pending == 0) begin
            $display("All tests passed");
         end else begin
            $display("Some tests failed");
         end
         $finish;
      end
   end

   // watchdog, at most 8 cycles per request after a 10 cycle reset
   initial begin
      wait (num_vecs > 0);
      #((10 + num_vecs * 8) * 8);
      $display("timeout: the requests did not finish in the expected time");
      $display("Some tests failed");
      $finish;
   end

endmodule

//--- dv/iob_wb_vectors.txt
# name addr wdata wstrb exp_rdata, all fields after the name in hex
# wstrb 0 is a read and exp_rdata is checked only for reads
wr_full_00 00000000 deadbeef f 00000000
rd_full_00 00000000 00000000 0 deadbeef
wr_full_10 00000010 12345678 f 00000000
wr_b0_10 00000010 000000aa 1 00000000
wr_b2_10 00000010 00cc0000 4 00000000
rd_merge_10 00000010 00000000 0 12cc56aa
wr_full_24 00000024 a5a5a5a5 f 00000000
wr_b13_24 00000024 11223344 a 00000000
rd_merge_24 00000024 00000000 0 11a533a5
rd_offset_13 00000013 00000000 0 12cc56aa
rd_offset_26 00000026 00000000 0 11a533a5
wr_alias_108 00000108 cafef00d f 00000000
rd_alias_08 00000008 00000000 0 cafef00d
rd_alias_f008 0000f008 00000000 0 cafef00d
wr_full_fc 000000fc 0badc0de f 00000000
rd_wrap_1fc 000001fc 00000000 0 0badc0de
b2b_wr_20 00000020 01010101 f 00000000
b2b_wr_30 00000030 02020202 f 00000000
b2b_rd_20 00000020 00000000 0 01010101
b2b_rd_30 00000030 00000000 0 02020202
b2b_wr_b1_00 00000000 0000ff00 2 00000000
b2b_rd_00 00000000 00000000 0 deadffef

//--- dv/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
   output logic clk_o
);

   // 8 ns period
   initial clk_o = 1'b0;

   always #4 clk_o = ~clk_o;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the IOb to Wishbone testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f compile.f --top-module iob_wb_tb -o iob_wb_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_output=$(./obj_dir/iob_wb_sim 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

# the run counts as passed only if the testbench printed the pass line
if grep -qx "All tests passed" <<< "$sim_output"; then
   exit 0
fi
echo "pass line not found in simulation output"
exit 1
